// ==== design/cp0_pkg.sv ====
package cp0_pkg;

	localparam int DATA_W = 32;
	localparam int REG_ADDR_W = 5;

	// Single bits inside Status and Cause
	localparam int STATUS_IE_BIT = 0;
	localparam int STATUS_EXL_BIT = 1;
	localparam int CAUSE_BD_BIT = 31;

	// CP0 register numbers, APB address bits 6:2
	typedef enum logic [REG_ADDR_W-1:0] {
		REG_BADVADDR = 5'd8,
		REG_COUNT = 5'd9,
		REG_COMPARE = 5'd11,
		REG_STATUS = 5'd12,
		REG_CAUSE = 5'd13,
		REG_EPC = 5'd14,
		REG_PRID = 5'd15,
		REG_CONFIG = 5'd16
	} cp0_reg_e;

	// ExcCode field values
	// ERET uses a reserved code and never reaches Cause
	typedef enum logic [4:0] {
		EXC_INT = 5'd0,
		EXC_ADEL = 5'd4,
		EXC_ADES = 5'd5,
		EXC_SYS = 5'd8,
		EXC_BP = 5'd9,
		EXC_RI = 5'd10,
		EXC_OV = 5'd12,
		EXC_ERET = 5'd31
	} exc_code_e;

	typedef enum logic [1:0] {
		APB_IDLE,
		APB_SETUP,
		APB_ACCESS
	} apb_state_e;

	// BEV set out of reset
	localparam logic [DATA_W-1:0] STATUS_RESET = 32'h0040_0000;

	// Big endian core, bit 15
	localparam logic [DATA_W-1:0] CONFIG_RESET = 32'h0000_8000;

	localparam logic [DATA_W-1:0] PRID_RESET = 32'h004c_0102;

	// IM in 15:8 and IE in bit 0
	localparam logic [DATA_W-1:0] STATUS_WMASK = 32'h0000_ff01;

	// Software interrupt bits IP[1:0]
	localparam logic [DATA_W-1:0] CAUSE_WMASK = 32'h0000_0300;

endpackage

// ==== design/cp0_exc_if.sv ====
interface cp0_exc_if;

	// Exception record from the encoder
	logic valid;
	cp0_pkg::exc_code_e code;
	logic [cp0_pkg::DATA_W-1:0] epc;
	logic [cp0_pkg::DATA_W-1:0] bad_addr;
	logic bd;

	// Status view for the interrupt decision
	logic status_ie;
	logic status_exl;
	logic [7:0] int_pend;

	modport producer (
		output valid, code, epc, bad_addr, bd,
		input status_ie, status_exl, int_pend
	);

	modport consumer (
		input valid, code, epc, bad_addr, bd,
		output status_ie, status_exl, int_pend
	);

endinterface

// ==== design/cp0_csr_if.sv ====
interface cp0_csr_if;

	logic wr_en;
	logic [cp0_pkg::REG_ADDR_W-1:0] addr;
	logic [cp0_pkg::DATA_W-1:0] wdata;

	// Read data for addr, no latency
	logic [cp0_pkg::DATA_W-1:0] rdata;

	modport initiator (
		output wr_en,
		output addr,
		output wdata,
		input rdata
	);

	modport target (
		input wr_en,
		input addr,
		input wdata,
		output rdata
	);

endinterface

// ==== design/cp0_exc_encoder.sv ====
module cp0_exc_encoder (
	input  logic clk,
	input  logic rst_n_i,
	input  logic inst_valid_i,
	input  logic [31:0] pc_i,
	input  logic [31:0] bad_addr_i,
	input  logic in_delay_slot_i,
	input  logic adel_i,
	input  logic ades_i,
	input  logic syscall_i,
	input  logic break_i,
	input  logic ri_i,
	input  logic ov_i,
	input  logic eret_i,
	cp0_exc_if.producer exc
);

	logic int_take;
	logic hit;
	cp0_pkg::exc_code_e code_d;

	// Interrupts only outside exception level
	assign int_take = exc.status_ie && !exc.status_exl && (|exc.int_pend);

	// Fixed priority, interrupt first and ERET last
	always_comb begin
		hit = 1'b1;
		code_d = cp0_pkg::EXC_INT;
		if (int_take) begin
			code_d = cp0_pkg::EXC_INT;
		end else if (adel_i) begin
			code_d = cp0_pkg::EXC_ADEL;
		end else if (ri_i) begin
			code_d = cp0_pkg::EXC_RI;
		end else if (ov_i) begin
			code_d = cp0_pkg::EXC_OV;
		end else if (syscall_i) begin
			code_d = cp0_pkg::EXC_SYS;
		end else if (break_i) begin
			code_d = cp0_pkg::EXC_BP;
		end else if (ades_i) begin
			code_d = cp0_pkg::EXC_ADES;
		end else if (eret_i) begin
			code_d = cp0_pkg::EXC_ERET;
		end else begin
			hit = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			exc.valid <= 1'b0;
		end else begin
			exc.valid <= inst_valid_i && hit;
		end
	end

	// Record payload
	always_ff @(posedge clk) begin
		exc.code <= code_d;
		// Restart at the branch when the fault sits in a delay slot
		if (in_delay_slot_i) begin
			exc.epc <= pc_i - 32'd4;
		end else begin
			exc.epc <= pc_i;
		end
		exc.bd <= in_delay_slot_i;
		exc.bad_addr <= bad_addr_i;
	end

endmodule

// ==== design/cp0_regs.sv ====
module cp0_regs (
	input  logic clk,
	input  logic rst_n_i,
	input  logic [5:0] int_i,
	cp0_csr_if.target csr,
	cp0_exc_if.consumer exc,
	output logic timer_int_o,
	output logic [cp0_pkg::DATA_W-1:0] status_o,
	output logic [cp0_pkg::DATA_W-1:0] cause_o,
	output logic [cp0_pkg::DATA_W-1:0] epc_o
);

	logic [cp0_pkg::DATA_W-1:0] count_q;
	logic [cp0_pkg::DATA_W-1:0] compare_q;
	logic [cp0_pkg::DATA_W-1:0] status_q;
	logic [cp0_pkg::DATA_W-1:0] cause_q;
	logic [cp0_pkg::DATA_W-1:0] epc_q;
	logic [cp0_pkg::DATA_W-1:0] badvaddr_q;

	logic wr_count;
	logic wr_compare;
	logic wr_status;
	logic wr_cause;
	logic wr_epc;
	logic exc_take;
	logic exc_eret;
	logic exc_addr;

	assign wr_count = csr.wr_en && (csr.addr == cp0_pkg::REG_COUNT);
	assign wr_compare = csr.wr_en && (csr.addr == cp0_pkg::REG_COMPARE);
	assign wr_status = csr.wr_en && (csr.addr == cp0_pkg::REG_STATUS);
	assign wr_cause = csr.wr_en && (csr.addr == cp0_pkg::REG_CAUSE);
	assign wr_epc = csr.wr_en && (csr.addr == cp0_pkg::REG_EPC);

	assign exc_eret = exc.valid && (exc.code == cp0_pkg::EXC_ERET);
	assign exc_take = exc.valid && (exc.code != cp0_pkg::EXC_ERET);
	assign exc_addr = (exc.code == cp0_pkg::EXC_ADEL) || (exc.code == cp0_pkg::EXC_ADES);

	// Count and the timer compare
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			count_q <= '0;
			compare_q <= '0;
			timer_int_o <= 1'b0;
		end else begin
			if (wr_count) begin
				count_q <= csr.wdata;
			end else begin
				count_q <= count_q + 32'd1;
			end
			if (wr_compare) begin
				compare_q <= csr.wdata;
				timer_int_o <= 1'b0;
			end else if (compare_q != '0 && count_q == compare_q) begin
				timer_int_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			status_q <= cp0_pkg::STATUS_RESET;
			cause_q <= '0;
			epc_q <= '0;
			badvaddr_q <= '0;
		end else begin
			if (wr_status) begin
				status_q <= (status_q & ~cp0_pkg::STATUS_WMASK) |
					(csr.wdata & cp0_pkg::STATUS_WMASK);
			end
			if (wr_cause) begin
				cause_q <= (cause_q & ~cp0_pkg::CAUSE_WMASK) |
					(csr.wdata & cp0_pkg::CAUSE_WMASK);
			end
			// Hardware interrupt lines
			cause_q[15:10] <= int_i;
			if (wr_epc) begin
				epc_q <= csr.wdata;
			end

			// Exception side effects land after software writes
			if (exc_take) begin
				status_q[cp0_pkg::STATUS_EXL_BIT] <= 1'b1;
				epc_q <= exc.epc;
				cause_q[cp0_pkg::CAUSE_BD_BIT] <= exc.bd;
				cause_q[6:2] <= exc.code;
				if (exc_addr) begin
					badvaddr_q <= exc.bad_addr;
				end
			end else if (exc_eret) begin
				status_q[cp0_pkg::STATUS_EXL_BIT] <= 1'b0;
			end
		end
	end

	always_comb begin
		case (csr.addr)
			cp0_pkg::REG_BADVADDR: csr.rdata = badvaddr_q;
			cp0_pkg::REG_COUNT: csr.rdata = count_q;
			cp0_pkg::REG_COMPARE: csr.rdata = compare_q;
			cp0_pkg::REG_STATUS: csr.rdata = status_q;
			cp0_pkg::REG_CAUSE: csr.rdata = cause_q;
			cp0_pkg::REG_EPC: csr.rdata = epc_q;
			cp0_pkg::REG_PRID: csr.rdata = cp0_pkg::PRID_RESET;
			cp0_pkg::REG_CONFIG: csr.rdata = cp0_pkg::CONFIG_RESET;
			default: csr.rdata = '0;
		endcase
	end

	// Masked pending interrupts for the encoder
	assign exc.status_ie = status_q[cp0_pkg::STATUS_IE_BIT];
	assign exc.status_exl = status_q[cp0_pkg::STATUS_EXL_BIT];
	assign exc.int_pend = status_q[15:8] & cause_q[15:8];

	assign status_o = status_q;
	assign cause_o = cause_q;
	assign epc_o = epc_q;

endmodule

// ==== design/cp0_apb_port.sv ====
module cp0_apb_port (
	input  logic clk,
	input  logic rst_n_i,
	input  logic psel_i,
	input  logic penable_i,
	input  logic pwrite_i,
	input  logic [7:0] paddr_i,
	input  logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	cp0_csr_if.initiator csr
);

	cp0_pkg::apb_state_e state;
	cp0_pkg::apb_state_e state_q;
	logic [cp0_pkg::REG_ADDR_W-1:0] reg_num;
	logic reg_known;
	logic reg_ro;

	assign reg_num = paddr_i[6:2];

	always_comb begin
		reg_known = 1'b1;
		reg_ro = 1'b0;
		case (reg_num)
			cp0_pkg::REG_COUNT, cp0_pkg::REG_COMPARE, cp0_pkg::REG_STATUS,
			cp0_pkg::REG_CAUSE, cp0_pkg::REG_EPC: reg_ro = 1'b0;
			// Writes dropped quietly
			cp0_pkg::REG_BADVADDR, cp0_pkg::REG_PRID, cp0_pkg::REG_CONFIG: reg_ro = 1'b1;
			default: reg_known = 1'b0;
		endcase
	end

	// Phase of the current cycle, ACCESS only right after SETUP
	always_comb begin
		if (!psel_i) begin
			state = cp0_pkg::APB_IDLE;
		end else if (!penable_i) begin
			state = cp0_pkg::APB_SETUP;
		end else if (state_q == cp0_pkg::APB_SETUP) begin
			state = cp0_pkg::APB_ACCESS;
		end else begin
			state = cp0_pkg::APB_IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= cp0_pkg::APB_IDLE;
		end else begin
			state_q <= state;
		end
	end

	// No wait states
	assign pready_o = (state == cp0_pkg::APB_ACCESS);
	assign pslverr_o = pready_o && !reg_known;
	assign prdata_o = pready_o ? csr.rdata : '0;

	assign csr.wr_en = pready_o && pwrite_i && reg_known && !reg_ro;
	assign csr.addr = reg_num;
	assign csr.wdata = pwdata_i;

endmodule

// ==== design/cp0_top.sv ====
module cp0_top (
	input  logic clk,
	input  logic rst_n_i,
	// APB slave
	input  logic psel_i,
	input  logic penable_i,
	input  logic pwrite_i,
	input  logic [7:0] paddr_i,
	input  logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	// Retiring instruction faults
	input  logic inst_valid_i,
	input  logic [31:0] pc_i,
	input  logic [31:0] bad_addr_i,
	input  logic in_delay_slot_i,
	input  logic adel_i,
	input  logic ades_i,
	input  logic syscall_i,
	input  logic break_i,
	input  logic ri_i,
	input  logic ov_i,
	input  logic eret_i,
	input  logic [5:0] int_i,
	output logic timer_int_o,
	output logic [31:0] status_o,
	output logic [31:0] cause_o,
	output logic [31:0] epc_o
);

	cp0_exc_if exc_if ();
	cp0_csr_if csr_if ();

	cp0_apb_port cp0_apb_port_inst (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.paddr_i(paddr_i),
		.pwdata_i(pwdata_i),
		.prdata_o(prdata_o),
		.pready_o(pready_o),
		.pslverr_o(pslverr_o),
		.csr(csr_if.initiator)
	);

	cp0_exc_encoder cp0_exc_encoder_inst (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.inst_valid_i(inst_valid_i),
		.pc_i(pc_i),
		.bad_addr_i(bad_addr_i),
		.in_delay_slot_i(in_delay_slot_i),
		.adel_i(adel_i),
		.ades_i(ades_i),
		.syscall_i(syscall_i),
		.break_i(break_i),
		.ri_i(ri_i),
		.ov_i(ov_i),
		.eret_i(eret_i),
		.exc(exc_if.producer)
	);

	cp0_regs cp0_regs_inst (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.int_i(int_i),
		.csr(csr_if.target),
		.exc(exc_if.consumer),
		.timer_int_o(timer_int_o),
		.status_o(status_o),
		.cause_o(cause_o),
		.epc_o(epc_o)
	);

endmodule

// ==== tests/cp0_properties.sv ====
module cp0_properties (
	input logic clk,
	input logic rst_n_i,
	input logic pready_i,
	input logic psel_i,
	input logic penable_i,
	input logic timer_int_i,
	input logic compare_wr_i,
	input logic exc_valid_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// Ready only in an ACCESS cycle that follows SETUP
	pready_in_access: assert property (@(posedge clk)
		pready_i |-> (psel_i && penable_i && $past(psel_i && !penable_i)))
		else $error("pready seen outside the ACCESS phase");

	timer_clear: assert property (@(posedge clk)
		$fell(timer_int_i) |-> ($past(compare_wr_i) || $past(!rst_n_i)))
		else $error("timer interrupt fell without a Compare write");

	no_exc_in_reset: assert property (@(posedge clk) $past(!rst_n_i) |-> !exc_valid_i)
		else $error("exception record valid during reset");

endmodule

bind cp0_apb_port cp0_properties apb_props (
	.clk(clk),
	.rst_n_i(rst_n_i),
	.pready_i(pready_o),
	.psel_i(psel_i),
	.penable_i(penable_i),
	.timer_int_i(1'b0),
	.compare_wr_i(1'b0),
	.exc_valid_i(1'b0)
);

bind cp0_regs cp0_properties regs_props (
	.clk(clk),
	.rst_n_i(rst_n_i),
	.pready_i(1'b0),
	.psel_i(1'b0),
	.penable_i(1'b0),
	.timer_int_i(timer_int_o),
	.compare_wr_i(wr_compare),
	.exc_valid_i(exc.valid)
);

// ==== tests/cp0_tb.sv ====
module cp0_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// Rough cycle cost of all tests together
	localparam int TEST_CYCLES = 5400;
	localparam int CYCLE_LIMIT = 4 * TEST_CYCLES;

	logic clk = 1'b0;
	logic rst_n_i;
	logic psel_i, penable_i, pwrite_i;
	logic [7:0] paddr_i;
	logic [31:0] pwdata_i, prdata_o;
	logic pready_o, pslverr_o;
	logic inst_valid_i, in_delay_slot_i;
	logic adel_i, ades_i, syscall_i, break_i, ri_i, ov_i, eret_i;
	logic [31:0] pc_i, bad_addr_i;
	logic [5:0] int_i;
	logic timer_int_o;
	logic [31:0] status_o, cause_o, epc_o;

	// Reference model state
	logic [31:0] m_count, m_compare, m_status, m_cause, m_epc, m_badvaddr;
	logic m_timer, m_prev_setup;
	logic m_rec_valid, m_rec_eret, m_rec_bd;
	logic [4:0] m_rec_code;
	logic [31:0] m_rec_epc, m_rec_bad;
	logic checking = 1'b0;
	int cycles = 0;
	logic [4:0] rw_regs [5] = '{5'd9, 5'd11, 5'd12, 5'd13, 5'd14};

	cp0_top cp0_top_inst (.*);

	always #50 clk = ~clk;

	function automatic logic known(input logic [4:0] num);
		return (num == 5'd8) || (num == 5'd9) || (num >= 5'd11 && num <= 5'd16);
	endfunction

	function automatic logic writable(input logic [4:0] num);
		return (num == 5'd9) || (num >= 5'd11 && num <= 5'd14);
	endfunction

	function automatic logic [31:0] model_read(input logic [4:0] num);
		case (num)
			5'd8: return m_badvaddr;
			5'd9: return m_count;
			5'd11: return m_compare;
			5'd12: return m_status;
			5'd13: return m_cause;
			5'd14: return m_epc;
			5'd15: return cp0_pkg::PRID_RESET;
			5'd16: return cp0_pkg::CONFIG_RESET;
			default: return 32'd0;
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
			$display("Verification failed");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	// Cycle model, sees the inputs as the DUT samples them
	always @(posedge clk) begin
		logic access, take_int, hit, wr, eret;
		logic [4:0] num, code;
		if (!rst_n_i) begin
			m_count = 32'd0;
			m_compare = 32'd0;
			m_timer = 1'b0;
			m_status = cp0_pkg::STATUS_RESET;
			m_cause = 32'd0;
			m_epc = 32'd0;
			m_badvaddr = 32'd0;
			m_rec_valid = 1'b0;
			m_prev_setup = 1'b0;
		end else begin
			access = psel_i && penable_i && m_prev_setup;
			m_prev_setup = psel_i && !penable_i;
			num = paddr_i[6:2];
			wr = access && pwrite_i && writable(num);
			take_int = m_status[0] && !m_status[1] && (|(m_status[15:8] & m_cause[15:8]));
			hit = 1'b1;
			eret = 1'b0;
			code = 5'd0;
			if (take_int) code = 5'd0;
			else if (adel_i) code = 5'd4;
			else if (ri_i) code = 5'd10;
			else if (ov_i) code = 5'd12;
			else if (syscall_i) code = 5'd8;
			else if (break_i) code = 5'd9;
			else if (ades_i) code = 5'd5;
			else if (eret_i) eret = 1'b1;
			else hit = 1'b0;

			if (wr && num == 5'd11) m_timer = 1'b0;
			else if (m_compare != 32'd0 && m_count == m_compare) m_timer = 1'b1;
			if (wr && num == 5'd11) m_compare = pwdata_i;
			if (wr && num == 5'd9) m_count = pwdata_i;
			else m_count = m_count + 32'd1;
			if (wr && num == 5'd12)
				m_status = (m_status & ~cp0_pkg::STATUS_WMASK) | (pwdata_i & cp0_pkg::STATUS_WMASK);
			if (wr && num == 5'd13)
				m_cause = (m_cause & ~cp0_pkg::CAUSE_WMASK) | (pwdata_i & cp0_pkg::CAUSE_WMASK);
			m_cause[15:10] = int_i;
			if (wr && num == 5'd14) m_epc = pwdata_i;

			// Previous record overrides software writes
			if (m_rec_valid && !m_rec_eret) begin
				m_status[1] = 1'b1;
				m_epc = m_rec_epc;
				m_cause[31] = m_rec_bd;
				m_cause[6:2] = m_rec_code;
				if (m_rec_code == 5'd4 || m_rec_code == 5'd5) m_badvaddr = m_rec_bad;
			end else if (m_rec_valid) begin
				m_status[1] = 1'b0;
			end
			m_rec_valid = inst_valid_i && hit;
			m_rec_eret = eret;
			m_rec_code = code;
			m_rec_epc = in_delay_slot_i ? pc_i - 32'd4 : pc_i;
			m_rec_bd = in_delay_slot_i;
			m_rec_bad = bad_addr_i;
		end
	end

	always @(negedge clk) begin
		if (checking) begin
			check("status_o", m_status, status_o);
			check("cause_o", m_cause, cause_o);
			check("epc_o", m_epc, epc_o);
			check("timer_int_o", {31'd0, m_timer}, {31'd0, timer_int_o});
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the tests did not finish", CYCLE_LIMIT);
			$display("Verification failed");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	// One APB transfer, optionally with a SYSCALL landing on the commit edge
	task automatic apb_xfer(input logic wr, input logic [4:0] num, input logic [31:0] data,
			input logic with_exc);
		logic exc_go;
		@(negedge clk);
		exc_go = with_exc && !m_status[1];
		@(posedge clk);
		psel_i <= 1'b1;
		penable_i <= 1'b0;
		pwrite_i <= wr;
		paddr_i <= {1'($urandom), num, 2'($urandom)};
		pwdata_i <= data;
		if (exc_go) begin
			inst_valid_i <= 1'b1;
			syscall_i <= 1'b1;
			pc_i <= $urandom;
			in_delay_slot_i <= 1'($urandom);
		end
		@(posedge clk);
		penable_i <= 1'b1;
		inst_valid_i <= 1'b0;
		syscall_i <= 1'b0;
		@(negedge clk);
		check("pready_o", 32'd1, {31'd0, pready_o});
		check("pslverr_o", {31'd0, !known(num)}, {31'd0, pslverr_o});
		if (!wr) check("prdata_o", model_read(num), prdata_o);
		@(posedge clk);
		psel_i <= 1'b0;
		penable_i <= 1'b0;
	endtask

	// One retiring instruction, forced to ERET while EXL is set
	task automatic retire(input logic [5:0] flags, input logic eret);
		logic exl;
		@(negedge clk);
		exl = m_status[1];
		@(posedge clk);
		inst_valid_i <= 1'b1;
		{adel_i, ades_i, syscall_i, break_i, ri_i, ov_i} <= exl ? 6'd0 : flags;
		eret_i <= exl ? 1'b1 : eret;
		pc_i <= $urandom;
		bad_addr_i <= $urandom;
		in_delay_slot_i <= 1'($urandom);
		@(posedge clk);
		inst_valid_i <= 1'b0;
		{adel_i, ades_i, syscall_i, break_i, ri_i, ov_i} <= 6'd0;
		eret_i <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	initial begin
		logic [4:0] num;
		logic [31:0] target;
		void'($urandom(58482));
		rst_n_i = 1'b0;
		{psel_i, penable_i, pwrite_i, paddr_i, pwdata_i} = '0;
		{in_delay_slot_i, pc_i, bad_addr_i, int_i} = '0;
		{adel_i, ades_i, break_i, ri_i, ov_i, eret_i} = '0;
		// A fault held through reset must leave no record
		inst_valid_i = 1'b1;
		syscall_i = 1'b1;
		repeat (10) @(posedge clk);
		rst_n_i <= 1'b1;
		inst_valid_i <= 1'b0;
		syscall_i <= 1'b0;
		@(negedge clk);
		checking = 1'b1;

		// Reset values
		check("reset pready_o", 32'd0, {31'd0, pready_o});
		check("reset pslverr_o", 32'd0, {31'd0, pslverr_o});
		check("reset status", cp0_pkg::STATUS_RESET, status_o);
		for (int r = 8; r <= 16; r++) apb_xfer(1'b0, 5'(r), 32'd0, 1'b0);

		// Write masks and bad addresses
		for (int i = 0; i < 200; i++) begin
			if (($urandom % 8) == 0) begin
				do num = 5'($urandom); while (known(num));
			end else begin
				num = rw_regs[$urandom % 5];
			end
			apb_xfer(1'b1, num, $urandom, 1'b0);
			apb_xfer(1'b0, num, 32'd0, 1'b0);
		end

		// Timer
		apb_xfer(1'b1, 5'd11, 32'd0, 1'b0);
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			target = m_count + 32'd10 + ($urandom % 30);
			apb_xfer(1'b1, 5'd11, target, 1'b0);
			while (!timer_int_o) @(negedge clk);
			apb_xfer(1'b1, 5'd11, 32'd0, 1'b0);
			@(negedge clk);
			check("timer cleared", 32'd0, {31'd0, timer_int_o});
		end

		// Exceptions
		for (int i = 0; i < 300; i++) begin
			retire(6'($urandom & $urandom), 1'(($urandom % 4) == 0));
			if ((i % 4) == 0) apb_xfer(1'b0, 5'd8, 32'd0, 1'b0);
		end

		// Interrupts and ERET
		for (int i = 0; i < 100; i++) begin
			apb_xfer(1'b1, 5'd12, $urandom, 1'b0);
			apb_xfer(1'b1, 5'd13, $urandom, 1'b0);
			@(posedge clk);
			int_i <= 6'($urandom);
			retire(6'd0, 1'b0);
		end

		// Collisions with software writes
		for (int i = 0; i < 40; i++) begin
			apb_xfer(1'b1, (i % 2) ? 5'd14 : 5'd12, $urandom, 1'b1);
			retire(6'd0, 1'b1);
		end

		$display("Verification passed");
		$finish;
	end

endmodule

// ==== sources.f ====
design/cp0_pkg.sv
design/cp0_exc_if.sv
design/cp0_csr_if.sv
design/cp0_exc_encoder.sv
design/cp0_regs.sv
design/cp0_apb_port.sv
design/cp0_top.sv
tests/cp0_properties.sv
tests/cp0_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CP0 testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module cp0_tb -o cp0_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cp0_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Verification passed" sim.log; then
	exit 0
fi
exit 1
